/* design/segment_pkg.sv */
package segment_pkg;

  ////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////

  // bounds and segment ends
  parameter int data_width = 8;

  ////////////////////////////////////////////////////////////////////
  // segment kinds
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // nothing legal
    seg_none    = 2'd0,
    // min value up to c_less_than-1
    seg_below   = 2'd1,
    // c_more_than+1 up to max value
    seg_above   = 2'd2,
    // interior interval, or full range when no constraint is on
    seg_between = 2'd3
  } seg_type_e;

  ////////////////////////////////////////////////////////////////////
  // segment and stage records
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    seg_type_e                    kind;
    logic signed [data_width-1:0] from;
    logic signed [data_width-1:0] to;
    // number of values minus one, zero for seg_none
    logic        [data_width-1:0] weight;
  } segment_t;

  // stage 1 result
  typedef struct packed {
    segment_t seg_a;
    segment_t seg_b;
    // both segments real, pick needed
    logic     two_way;
  } candidates_t;

  // stage 2 result
  typedef struct packed {
    candidates_t           cand;
    // legal values over both candidates
    logic [data_width:0]   total;
  } weighed_t;

endpackage

/* design/constraint_decode.sv */
module constraint_decode #(
  parameter int data_width = segment_pkg::data_width
) (
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         enable,
  input  logic signed [data_width-1:0] c_less_than,
  input  logic signed [data_width-1:0] c_more_than,
  input  logic [1:0]                   flag,
  output segment_pkg::candidates_t     cand,
  output logic                         cand_valid
);

  // signed range limits
  localparam logic signed [data_width-1:0] min_val = {1'b1, {(data_width-1){1'b0}}};
  localparam logic signed [data_width-1:0] max_val = {1'b0, {(data_width-1){1'b1}}};

  // edge interval ends
  logic signed [data_width-1:0] lo_end;
  logic signed [data_width-1:0] hi_start;
  logic                         lo_empty;
  logic                         hi_empty;

  // building blocks for the candidate pair
  segment_pkg::segment_t        none_seg;
  segment_pkg::segment_t        full_seg;
  segment_pkg::segment_t        below_seg;
  segment_pkg::segment_t        above_seg;
  segment_pkg::segment_t        between_seg;
  segment_pkg::candidates_t     next_cand;

  ////////////////////////////////////////////////////////////////////
  // edge intervals
  ////////////////////////////////////////////////////////////////////

  // nothing below the minimum, nothing above the maximum
  assign lo_empty = (c_less_than == min_val);
  assign hi_empty = (c_more_than == max_val);
  assign lo_end   = c_less_than - 1'b1;
  assign hi_start = c_more_than + 1'b1;

  // weights left at zero, filled in by the weigher
  assign none_seg    = '{kind: segment_pkg::seg_none, from: '0, to: '0, weight: '0};
  assign full_seg    = '{kind: segment_pkg::seg_between, from: min_val, to: max_val,
                         weight: '0};
  assign below_seg   = '{kind: segment_pkg::seg_below, from: min_val, to: lo_end,
                         weight: '0};
  assign above_seg   = '{kind: segment_pkg::seg_above, from: hi_start, to: max_val,
                         weight: '0};
  assign between_seg = '{kind: segment_pkg::seg_between, from: hi_start, to: lo_end,
                         weight: '0};

  ////////////////////////////////////////////////////////////////////
  // candidate selection by flag
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    next_cand.seg_a   = none_seg;
    next_cand.seg_b   = none_seg;
    next_cand.two_way = 1'b0;
    case (flag)
      // no constraint
      2'b00: next_cand.seg_a = full_seg;
      // value < c_less_than only
      2'b01: next_cand.seg_a = lo_empty ? none_seg : below_seg;
      // value > c_more_than only
      2'b10: next_cand.seg_a = hi_empty ? none_seg : above_seg;
      default: begin
        // room between bounds, guard against wrapped ends
        if (!lo_empty && !hi_empty && (hi_start <= lo_end)) begin
          next_cand.seg_a = between_seg;
        end else if (!lo_empty && !hi_empty) begin
          next_cand.seg_a   = below_seg;
          next_cand.seg_b   = above_seg;
          next_cand.two_way = 1'b1;
        end else if (!lo_empty) begin
          next_cand.seg_a = below_seg;
        end else if (!hi_empty) begin
          // lone survivor moves to seg_a
          next_cand.seg_a = above_seg;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // stage 1 register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      cand_valid <= 1'b0;
    end else begin
      cand_valid <= enable;
    end
  end

  // payload only moves on an accepted request
  always_ff @(posedge clock) begin
    if (enable) begin
      cand <= next_cand;
    end
  end

endmodule

/* design/segment_weigher.sv */
module segment_weigher #(
  parameter int data_width = segment_pkg::data_width
) (
  input  logic                     clock,
  input  logic                     rst_n,
  input  segment_pkg::candidates_t cand,
  input  logic                     cand_valid,
  output segment_pkg::weighed_t    weighed,
  output logic                     weighed_valid
);

  // value counts per candidate
  logic [data_width:0]      count_a;
  logic [data_width:0]      count_b;
  segment_pkg::weighed_t    next_weighed;

  // to minus from, wraps cleanly for the full range
  function automatic logic [data_width-1:0] seg_weight(input segment_pkg::segment_t seg);
    logic [data_width-1:0] diff;
    diff = seg.to - seg.from;
    if (seg.kind == segment_pkg::seg_none) begin
      diff = '0;
    end
    return diff;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // weights and total
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    next_weighed.cand              = cand;
    next_weighed.cand.seg_a.weight = seg_weight(cand.seg_a);
    next_weighed.cand.seg_b.weight = seg_weight(cand.seg_b);
    // count is weight plus one, none counts nothing
    count_a = (cand.seg_a.kind == segment_pkg::seg_none) ? '0 :
              {1'b0, next_weighed.cand.seg_a.weight} + 1'b1;
    count_b = (cand.seg_b.kind == segment_pkg::seg_none) ? '0 :
              {1'b0, next_weighed.cand.seg_b.weight} + 1'b1;
    next_weighed.total = count_a + count_b;
  end

  ////////////////////////////////////////////////////////////////////
  // stage 2 register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      weighed_valid <= 1'b0;
    end else begin
      weighed_valid <= cand_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (cand_valid) begin
      weighed <= next_weighed;
    end
  end

endmodule

/* design/segment_lfsr.sv */
module segment_lfsr (
  input  logic       clock,
  input  logic       rst_n,
  input  logic [7:0] seed,
  input  logic       step,
  output logic [7:0] rand_byte
);

  // galois taps, shift right form
  localparam logic [7:0] feedback_mask = 8'hB8;

  logic [7:0] state;
  logic [7:0] next_state;

  ////////////////////////////////////////////////////////////////////
  // one galois step
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state = {1'b0, state[7:1]};
    // bit shifted out decides the feedback
    if (state[0]) begin
      next_state = next_state ^ feedback_mask;
    end
  end

  // seed held through reset, zero would lock up
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= (seed == 8'h00) ? 8'h01 : seed;
    end else if (step) begin
      state <= next_state;
    end
  end

  assign rand_byte = state;

endmodule

/* design/segment_chooser.sv */
module segment_chooser (
  input  logic                  clock,
  input  logic                  rst_n,
  input  segment_pkg::weighed_t weighed,
  input  logic                  weighed_valid,
  input  logic [7:0]            rand_byte,
  output segment_pkg::segment_t chosen,
  output logic                  chosen_valid
);

  localparam int dw = segment_pkg::data_width;

  // random byte times total count
  logic [2*dw-1:0]       product;
  // random byte scaled into 0 .. total-1
  logic [dw-1:0]         scaled;
  logic                  pick_b;
  segment_pkg::segment_t next_chosen;

  ////////////////////////////////////////////////////////////////////
  // proportional pick
  ////////////////////////////////////////////////////////////////////

  // at most 255 * 256, fits in two bytes
  assign product = rand_byte * weighed.total;
  assign scaled  = product[2*dw-1:dw];

  // seg_a owns scaled values 0 .. weight_a
  assign pick_b = weighed.cand.two_way && (scaled > weighed.cand.seg_a.weight);

  always_comb begin
    if (pick_b) begin
      next_chosen = weighed.cand.seg_b;
    end else begin
      next_chosen = weighed.cand.seg_a;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // stage 3 register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      chosen_valid <= 1'b0;
    end else begin
      chosen_valid <= weighed_valid;
    end
  end

  // chosen holds until the next result
  always_ff @(posedge clock) begin
    if (weighed_valid) begin
      chosen <= next_chosen;
    end
  end

endmodule

/* design/select_segment.sv */
module select_segment #(
  parameter int data_width = segment_pkg::data_width
) (
  input  logic                         clock,
  input  logic                         rst_n,
  // one request per high cycle
  input  logic                         enable,
  input  logic [7:0]                   seed,
  input  logic signed [data_width-1:0] c_less_than,
  input  logic signed [data_width-1:0] c_more_than,
  // bit 0 less-than, bit 1 more-than
  input  logic [1:0]                   flag,
  output logic                         chosen_valid,
  output segment_pkg::segment_t        chosen
);

  ////////////////////////////////////////////////////////////////////
  // stage links
  ////////////////////////////////////////////////////////////////////

  segment_pkg::candidates_t cand;
  logic                     cand_valid;
  segment_pkg::weighed_t    weighed;
  logic                     weighed_valid;
  logic [7:0]               rand_byte;

  // stage 1, bounds to candidates
  constraint_decode #(
    .data_width (data_width)
  ) u_decode (
    .clock       (clock),
    .rst_n       (rst_n),
    .enable      (enable),
    .c_less_than (c_less_than),
    .c_more_than (c_more_than),
    .flag        (flag),
    .cand        (cand),
    .cand_valid  (cand_valid)
  );

  // stage 2, weights and total
  segment_weigher #(
    .data_width (data_width)
  ) u_weigher (
    .clock         (clock),
    .rst_n         (rst_n),
    .cand          (cand),
    .cand_valid    (cand_valid),
    .weighed       (weighed),
    .weighed_valid (weighed_valid)
  );

  // one lfsr step per request, in request order
  segment_lfsr u_lfsr (
    .clock     (clock),
    .rst_n     (rst_n),
    .seed      (seed),
    .step      (cand_valid),
    .rand_byte (rand_byte)
  );

  // stage 3, weighted pick
  segment_chooser u_chooser (
    .clock         (clock),
    .rst_n         (rst_n),
    .weighed       (weighed),
    .weighed_valid (weighed_valid),
    .rand_byte     (rand_byte),
    .chosen        (chosen),
    .chosen_valid  (chosen_valid)
  );

endmodule

/* verification/select_segment_checker.sv */
module select_segment_checker (
  input logic                  clock,
  input logic                  rst_n,
  input logic                  enable,
  input logic                  chosen_valid,
  input segment_pkg::segment_t chosen
);

  // width of the chosen segment
  logic [7:0] span;

  assign span = chosen.to - chosen.from;

  ////////////////////////////////////////////////////////////////////
  // pipeline timing
  ////////////////////////////////////////////////////////////////////

  // three register stages from request to result
  assert property (@(posedge clock) disable iff (!rst_n)
    enable |-> ##3 chosen_valid)
    else $error("request not answered three cycles later");

  // no result without a request
  assert property (@(posedge clock) disable iff (!rst_n)
    chosen_valid |-> $past(enable, 3))
    else $error("result with no request three cycles before");

  ////////////////////////////////////////////////////////////////////
  // output legality
  ////////////////////////////////////////////////////////////////////

  assert property (@(posedge clock) disable iff (!rst_n)
    (chosen_valid && chosen.kind != segment_pkg::seg_none) |->
      ($signed(chosen.from) <= $signed(chosen.to)))
    else $error("segment ends out of order");

  assert property (@(posedge clock) disable iff (!rst_n)
    (chosen_valid && chosen.kind != segment_pkg::seg_none) |-> (chosen.weight == span))
    else $error("segment weight does not match its ends");

endmodule

bind select_segment select_segment_checker u_checker (
  .clock        (clock),
  .rst_n        (rst_n),
  .enable       (enable),
  .chosen_valid (chosen_valid),
  .chosen       (chosen)
);

/* verification/select_segment_tb.sv */
module select_segment_tb;

  ////////////////////////////////////////////////////////////////////
  // sizes and limits
  ////////////////////////////////////////////////////////////////////

  localparam int num_entries   = 20;
  localparam int max_gap       = 3;
  localparam int rand_count    = 40;
  localparam int timeout_limit = num_entries * (max_gap + 3) + 10 + rand_count + 50;

  // one table row, expected segment unused for two-way rows
  typedef struct packed {
    logic signed [7:0]     lt;
    logic signed [7:0]     mt;
    logic [1:0]            flag;
    logic [1:0]            gap;
    logic                  two_way;
    segment_pkg::segment_t exp;
  } stim_t;

  logic                  clock;
  logic                  rst_n;
  logic                  enable;
  logic [7:0]            seed;
  logic signed [7:0]     c_less_than;
  logic signed [7:0]     c_more_than;
  logic [1:0]            flag;
  logic                  chosen_valid;
  segment_pkg::segment_t chosen;

  stim_t                 stim_table [num_entries];
  segment_pkg::segment_t expected_q [$];
  int                    due_q [$];
  segment_pkg::segment_t got_exp;
  segment_pkg::segment_t drv_exp;
  logic [7:0]            lfsr_state;
  logic signed [7:0]     drv_lt;
  logic signed [7:0]     drv_mt;
  int                    due;
  int                    cycle = 0;
  int                    timer_cycles = 0;
  bit                    seen_below;
  bit                    seen_above;

  select_segment #(
    .data_width (8)
  ) dut (
    .clock        (clock),
    .rst_n        (rst_n),
    .enable       (enable),
    .seed         (seed),
    .c_less_than  (c_less_than),
    .c_more_than  (c_more_than),
    .flag         (flag),
    .chosen_valid (chosen_valid),
    .chosen       (chosen)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////

  // galois step, shift right, mask on a one shifted out
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ({1'b0, s[7:1]} ^ 8'hB8) : {1'b0, s[7:1]};
  endfunction

  function automatic segment_pkg::segment_t make_seg(input segment_pkg::seg_type_e kind,
                                                     input int from, input int to);
    segment_pkg::segment_t s;
    s.kind   = kind;
    s.from   = 8'(from);
    s.to     = 8'(to);
    // count minus one
    s.weight = 8'(to - from);
    return s;
  endfunction

  function automatic segment_pkg::segment_t model_pick(input int lt, input int mt,
                                                       input int fl, input int rnd);
    int lo_end;
    int hi_start;
    int total;
    bit lo_ok;
    bit hi_ok;
    lo_end   = lt - 1;
    hi_start = mt + 1;
    lo_ok    = (lt > -128);
    hi_ok    = (mt < 127);
    case (fl)
      0: return make_seg(segment_pkg::seg_between, -128, 127);
      1: return lo_ok ? make_seg(segment_pkg::seg_below, -128, lo_end) :
                        make_seg(segment_pkg::seg_none, 0, 0);
      2: return hi_ok ? make_seg(segment_pkg::seg_above, hi_start, 127) :
                        make_seg(segment_pkg::seg_none, 0, 0);
      default: begin
        if (lo_ok && hi_ok && hi_start <= lo_end) begin
          return make_seg(segment_pkg::seg_between, hi_start, lo_end);
        end else if (lo_ok && hi_ok) begin
          // counts of both edges, then scaled random pick
          total = (lo_end + 129) + (128 - hi_start);
          if (((rnd * total) >> 8) > (lo_end + 128)) begin
            return make_seg(segment_pkg::seg_above, hi_start, 127);
          end
          return make_seg(segment_pkg::seg_below, -128, lo_end);
        end else if (lo_ok) begin
          return make_seg(segment_pkg::seg_below, -128, lo_end);
        end else if (hi_ok) begin
          return make_seg(segment_pkg::seg_above, hi_start, 127);
        end
        return make_seg(segment_pkg::seg_none, 0, 0);
      end
    endcase
  endfunction

  // ends do not matter for seg_none
  function automatic bit same_segment(input segment_pkg::segment_t a,
                                      input segment_pkg::segment_t b);
    if (a.kind != b.kind || a.weight != b.weight) begin
      return 1'b0;
    end
    return (a.kind == segment_pkg::seg_none) || (a.from == b.from && a.to == b.to);
  endfunction

  function automatic stim_t row(input int lt, input int mt, input int fl, input int gap,
                                input bit two_way, input segment_pkg::seg_type_e kind,
                                input int from, input int to);
    stim_t r;
    r.lt      = 8'(lt);
    r.mt      = 8'(mt);
    r.flag    = 2'(fl);
    r.gap     = 2'(gap);
    r.two_way = two_way;
    r.exp     = make_seg(kind, from, to);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  // called right after a rising edge
  task automatic drive_request(input logic signed [7:0] lt, input logic signed [7:0] mt,
                               input logic [1:0] fl, input int gap,
                               output segment_pkg::segment_t exp);
    lfsr_state = lfsr_next(lfsr_state);
    exp = model_pick(lt, mt, fl, lfsr_state);
    expected_q.push_back(exp);
    c_less_than <= lt;
    c_more_than <= mt;
    flag        <= fl;
    enable      <= 1'b1;
    @(posedge clock);
    if (gap > 0) begin
      enable <= 1'b0;
      repeat (gap) @(posedge clock);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // result monitor, sampled mid cycle
  ////////////////////////////////////////////////////////////////////

  always @(negedge clock) begin
    if (rst_n) begin
      if (chosen_valid) begin
        assert (expected_q.size() > 0 && due_q.size() > 0)
          else fail_now("chosen_valid rose with no request pending");
        got_exp = expected_q.pop_front();
        due     = due_q.pop_front();
        assert (due == cycle)
          else fail_now($sformatf("result at cycle %0d, due at %0d", cycle, due));
        assert (same_segment(chosen, got_exp))
          else fail_now($sformatf("got kind %0d %0d..%0d w %0d, expected kind %0d %0d..%0d w %0d",
                        chosen.kind, chosen.from, chosen.to, chosen.weight,
                        got_exp.kind, got_exp.from, got_exp.to, got_exp.weight));
      end else if (due_q.size() > 0) begin
        assert (due_q[0] > cycle)
          else fail_now($sformatf("result due at cycle %0d never came", due_q[0]));
      end
      // three stage registers ahead
      if (enable) begin
        due_q.push_back(cycle + 3);
      end
    end
    cycle = cycle + 1;
  end

  always @(posedge clock) begin
    timer_cycles = timer_cycles + 1;
    if (timer_cycles > timeout_limit) begin
      $display("simulation ran past %0d cycles without finishing", timeout_limit);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h4923));
    rst_n       = 1'b0;
    enable      = 1'b0;
    seed        = 8'h01;
    c_less_than = '0;
    c_more_than = '0;
    flag        = 2'b00;
    lfsr_state  = 8'h01;
    seen_below  = 1'b0;
    seen_above  = 1'b0;

    // interior gaps over sign mixes
    stim_table[0]  = row(50, 10, 3, 0, 0, segment_pkg::seg_between, 11, 49);
    stim_table[1]  = row(-10, -50, 3, 1, 0, segment_pkg::seg_between, -49, -11);
    stim_table[2]  = row(20, -20, 3, 0, 0, segment_pkg::seg_between, -19, 19);
    stim_table[3]  = row(5, 0, 3, 2, 0, segment_pkg::seg_between, 1, 4);
    stim_table[4]  = row(5, 3, 3, 0, 0, segment_pkg::seg_between, 4, 4);
    // single edges, limits give nothing
    stim_table[5]  = row(0, 0, 1, 0, 0, segment_pkg::seg_below, -128, -1);
    stim_table[6]  = row(-128, 0, 1, 1, 0, segment_pkg::seg_none, 0, 0);
    stim_table[7]  = row(127, 0, 1, 0, 0, segment_pkg::seg_below, -128, 126);
    stim_table[8]  = row(-127, 0, 1, 0, 0, segment_pkg::seg_below, -128, -128);
    stim_table[9]  = row(0, 0, 2, 3, 0, segment_pkg::seg_above, 1, 127);
    stim_table[10] = row(0, 127, 2, 0, 0, segment_pkg::seg_none, 0, 0);
    stim_table[11] = row(0, -128, 2, 0, 0, segment_pkg::seg_above, -127, 127);
    stim_table[12] = row(0, 126, 2, 1, 0, segment_pkg::seg_above, 127, 127);
    // full range
    stim_table[13] = row(0, 0, 0, 0, 0, segment_pkg::seg_between, -128, 127);
    // crossed bounds
    stim_table[14] = row(1, 8, 3, 0, 1, segment_pkg::seg_none, 0, 0);
    stim_table[15] = row(0, 0, 3, 2, 1, segment_pkg::seg_none, 0, 0);
    stim_table[16] = row(-128, 5, 3, 0, 0, segment_pkg::seg_above, 6, 127);
    stim_table[17] = row(10, 127, 3, 1, 0, segment_pkg::seg_below, -128, 9);
    stim_table[18] = row(-128, 127, 3, 0, 0, segment_pkg::seg_none, 0, 0);
    stim_table[19] = row(1, 8, 3, 0, 1, segment_pkg::seg_none, 0, 0);

    repeat (10) @(posedge clock);
    rst_n <= 1'b1;
    @(posedge clock);

    for (int i = 0; i < num_entries; i++) begin
      drv_lt = stim_table[i].lt;
      drv_mt = stim_table[i].mt;
      // unused bounds get random values
      if (!stim_table[i].flag[0]) drv_lt = 8'($urandom_range(0, 255));
      if (!stim_table[i].flag[1]) drv_mt = 8'($urandom_range(0, 255));
      drive_request(drv_lt, drv_mt, stim_table[i].flag, stim_table[i].gap, drv_exp);
      if (!stim_table[i].two_way) begin
        assert (same_segment(drv_exp, stim_table[i].exp))
          else fail_now($sformatf("model and table disagree on row %0d", i));
      end
    end

    // crossed bounds back to back, always a two-way pick
    for (int i = 0; i < rand_count; i++) begin
      drv_lt = 8'($urandom_range(0, 200) - 100);
      drv_mt = drv_lt + 8'($urandom_range(0, 20));
      drive_request(drv_lt, drv_mt, 2'b11, 0, drv_exp);
      if (drv_exp.kind == segment_pkg::seg_below) seen_below = 1'b1;
      if (drv_exp.kind == segment_pkg::seg_above) seen_above = 1'b1;
    end
    enable <= 1'b0;

    while (due_q.size() != 0 || expected_q.size() != 0) @(posedge clock);
    // quiet tail, monitor flags any stray result
    repeat (5) @(posedge clock);
    assert (seen_below && seen_above) begin
      $display("Test passed");
    end else begin
      fail_now("random phase never picked both edge segments");
    end
    $finish;
  end

endmodule

/* build.f */
design/segment_pkg.sv
design/constraint_decode.sv
design/segment_weigher.sv
design/segment_lfsr.sv
design/segment_chooser.sv
design/select_segment.sv
verification/select_segment_checker.sv
verification/select_segment_tb.sv

/* Bender.yml */
package:
  name: select_segment

sources:
  - design/segment_pkg.sv
  - design/constraint_decode.sv
  - design/segment_weigher.sv
  - design/segment_lfsr.sv
  - design/segment_chooser.sv
  - design/select_segment.sv
  - target: test
    files:
      - verification/select_segment_checker.sv
      - verification/select_segment_tb.sv
